//--- include/core_demux_defines.svh
// ***************************************************************************
// Widths, memory map constants and register offsets for the core demux
// Region field of the address selects SH, PE or EXT
// ***************************************************************************

`ifndef CORE_DEMUX_DEFINES_SVH
`define CORE_DEMUX_DEFINES_SVH

// Bus widths
`define CD_ADDR_W       32
`define CD_DATA_W       32
`define CD_BE_W         4
`define CD_CID_W        6
`define CD_CNT_W        32

// Region field within the address
`define CD_REGION_MSB   31
`define CD_REGION_LSB   20

// Memory map rows
`define CD_TCDM_BASE    12'h100   // Cluster 0 base, four rows per cluster
`define CD_ALIAS_BASE   12'h000
`define CD_EXT_SEL_BIT  14        // Picks EXT inside row base+2

// Config register offsets
`define CD_WB_ADR_W     4
`define CD_REG_CTRL     4'h0
`define CD_REG_STALL_SH 4'h4
`define CD_REG_STALL_L2 4'h8

`endif

//--- verilog/core_demux_pkg.sv
// ***************************************************************************
// Shared types of the core demux
// Vector typedefs, request/response and Wishbone structs, enums
// ***************************************************************************

`include "core_demux_defines.svh"

package core_demux_pkg;

  typedef logic [`CD_ADDR_W-1:0]                     addr_t;
  typedef logic [`CD_DATA_W-1:0]                     data_t;
  typedef logic [`CD_BE_W-1:0]                       be_t;
  typedef logic [`CD_CID_W-1:0]                      cluster_id_t;
  typedef logic [`CD_REGION_MSB-`CD_REGION_LSB:0]    region_t;
  typedef logic [`CD_CNT_W-1:0]                      cnt_t;
  typedef logic [`CD_WB_ADR_W-1:0]                   wb_adr_t;

  // Core load/store request, shared by all targets
  typedef struct packed {
    addr_t addr;
    logic  wen;    // 1 is a load
    data_t wdata;
    be_t   be;
  } core_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } core_rsp_t;

  // Wishbone classic master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    data_t   dat;
  } wb_req_t;

  typedef enum logic [1:0] {
    DEST_SH,
    DEST_PE,
    DEST_EXT
  } dest_e;

  typedef enum logic [1:0] {
    PE_IDLE,
    PE_PENDING,
    PE_GRANTED
  } pe_state_e;

endpackage

//--- verilog/demux_req_router.sv
// ***************************************************************************
// Request router of the core demux
// Decodes the region field, drives one target request line,
// returns that target's grant and flags stall cycles
// ***************************************************************************

`timescale 1ns/100ps
`include "core_demux_defines.svh"

module demux_req_router import core_demux_pkg::*; (
  input  logic        core_req_valid_i,
  input  core_req_t   core_req_i,
  input  cluster_id_t cluster_id_i,
  input  logic        alias_en_i,
  input  logic        sh_gnt_i,
  input  logic        ext_gnt_i,
  input  logic        pe_gnt_i,
  output core_req_t   tgt_req_o,
  output logic        sh_req_o,
  output logic        ext_req_o,
  output logic        pe_req_o,
  output logic        core_gnt_o,
  output logic        stall_sh_o,
  output logic        stall_l2_o,
  output dest_e       dest_o
);

  region_t region;
  region_t base_row;
  logic    hit_sh;
  logic    hit_dem;

  assign region   = core_req_i.addr[`CD_REGION_MSB:`CD_REGION_LSB];
  assign base_row = `CD_TCDM_BASE + region_t'({cluster_id_i, 2'b00});

  // Rows base+0/base+1 are TCDM, base+2 holds the demux peripherals
  assign hit_sh  = (region == base_row) || (region == base_row + region_t'(1)) ||
                   (alias_en_i && ((region == `CD_ALIAS_BASE) ||
                                   (region == `CD_ALIAS_BASE + region_t'(1))));
  assign hit_dem = (region == base_row + region_t'(2)) ||
                   (alias_en_i && (region == `CD_ALIAS_BASE + region_t'(2)));

  always_comb begin
    if (hit_sh) begin
      dest_o = DEST_SH;
    end else if (hit_dem && core_req_i.addr[`CD_EXT_SEL_BIT]) begin
      dest_o = DEST_EXT;
    end else begin
      dest_o = DEST_PE;                    // Rest of the map
    end
  end

  assign tgt_req_o = core_req_i;
  assign sh_req_o  = core_req_valid_i && hit_sh;
  assign ext_req_o = core_req_valid_i && hit_dem && core_req_i.addr[`CD_EXT_SEL_BIT];
  assign pe_req_o  = core_req_valid_i && (dest_o == DEST_PE);

  assign core_gnt_o = (sh_req_o & sh_gnt_i) | (ext_req_o & ext_gnt_i) | (pe_req_o & pe_gnt_i);

  assign stall_sh_o = sh_req_o & ~sh_gnt_i;
  assign stall_l2_o = (pe_req_o | ext_req_o) & ~core_gnt_o;  // Waiting on the L2 side

  // TCDM rows and the EXT rows must never overlap
  always_comb begin
    assert #0 ($onehot0({sh_req_o, ext_req_o, pe_req_o}))
      else $error("More than one target request line is high");
  end

endmodule

//--- verilog/periph_txn_ctrl.sv
// ***************************************************************************
// Peripheral transaction control
// Idle/pending/granted FSM toward the PE port and
// two-stage response pipeline back to the core
// ***************************************************************************

`timescale 1ns/100ps

module periph_txn_ctrl import core_demux_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      pe_req_i,
  input  logic      pe_gnt_i,
  input  logic      pe_rsp_valid_i,
  input  core_rsp_t pe_rsp_i,
  output logic      pe_req_o,
  output logic      core_gnt_o,
  output logic      rsp_valid_o,
  output core_rsp_t rsp_o
);

  pe_state_e state_q;
  pe_state_e state_d;
  logic      rsp_valid_0_q;
  core_rsp_t rsp_0_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      PE_IDLE: begin
        if (pe_req_i && pe_gnt_i) begin
          state_d = PE_PENDING;
        end
      end
      PE_PENDING: begin
        if (pe_rsp_valid_i) begin
          state_d = PE_GRANTED;            // Release the core next cycle
        end
      end
      PE_GRANTED: state_d = PE_IDLE;
      default:    state_d = PE_IDLE;
    endcase
  end

  // Only one PE transaction in flight
  assign pe_req_o   = pe_req_i && (state_q == PE_IDLE);
  assign core_gnt_o = (state_q == PE_GRANTED);

  // Response valid pipeline
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_0_q <= 1'b0;
      rsp_valid_o   <= 1'b0;
    end else begin
      rsp_valid_0_q <= pe_rsp_valid_i;
      rsp_valid_o   <= rsp_valid_0_q;
    end
  end

  // Response payload follows its valid
  always_ff @(posedge clk) begin
    if (pe_rsp_valid_i) begin
      rsp_0_q <= pe_rsp_i;
    end
    if (rsp_valid_0_q) begin
      rsp_o <= rsp_0_q;
    end
  end

  // Grant comes one cycle after the PE response, data one cycle after the grant
  a_gnt_after_rsp: assert property (@(posedge clk) disable iff (!rst_ni)
    core_gnt_o |-> $past(pe_rsp_valid_i));
  a_rsp_after_gnt: assert property (@(posedge clk) disable iff (!rst_ni)
    core_gnt_o |=> rsp_valid_o);

endmodule

//--- verilog/demux_resp_mux.sv
// ***************************************************************************
// Response mux of the core demux
// Registered destination and response selection toward the core
// ***************************************************************************

`timescale 1ns/100ps

module demux_resp_mux import core_demux_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      core_req_valid_i,
  input  dest_e     dest_i,
  input  logic      sh_rsp_valid_i,
  input  core_rsp_t sh_rsp_i,
  input  logic      pe_rsp_valid_i,
  input  core_rsp_t pe_rsp_i,
  input  logic      ext_rsp_valid_i,
  input  core_rsp_t ext_rsp_i,
  output logic      core_rsp_valid_o,
  output core_rsp_t core_rsp_o
);

  dest_e dest_q;

  // Remember where the current request went
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dest_q <= DEST_SH;
    end else if (core_req_valid_i) begin
      dest_q <= dest_i;
    end
  end

  always_comb begin
    case (dest_q)
      DEST_SH: begin
        core_rsp_valid_o = sh_rsp_valid_i;
        core_rsp_o.rdata = sh_rsp_i.rdata;
        core_rsp_o.err   = 1'b0;           // TCDM never errors
      end
      DEST_PE: begin
        core_rsp_valid_o = pe_rsp_valid_i;
        core_rsp_o       = pe_rsp_i;
      end
      DEST_EXT: begin
        core_rsp_valid_o = ext_rsp_valid_i;
        core_rsp_o       = ext_rsp_i;
      end
      default: begin
        core_rsp_valid_o = 1'b0;
        core_rsp_o       = '0;
      end
    endcase
  end

endmodule

//--- verilog/demux_cfg_regs.sv
// ***************************************************************************
// Configuration registers of the core demux
// Wishbone classic slave with CTRL (cluster id, alias and count
// enables) and the SH and L2 stall counters
// ***************************************************************************

`timescale 1ns/100ps
`include "core_demux_defines.svh"

module demux_cfg_regs import core_demux_pkg::*; (
  input  logic        clk,
  input  logic        rst_ni,
  input  wb_req_t     wb_i,
  input  logic        stall_sh_i,
  input  logic        stall_l2_i,
  output data_t       wb_dat_o,
  output logic        wb_ack_o,
  output cluster_id_t cluster_id_o,
  output logic        alias_en_o
);

  logic  access;
  logic  wr_en;
  logic  cnt_en_q;
  cnt_t  stall_sh_q;
  cnt_t  stall_l2_q;
  data_t rd_data;

  // New strobe, not yet acknowledged
  assign access = wb_i.cyc & wb_i.stb & ~wb_ack_o;
  assign wr_en  = access & wb_i.we;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= access;                  // Single-cycle ack
    end
  end

  // CTRL fields
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      cluster_id_o <= '0;
      alias_en_o   <= 1'b1;
      cnt_en_q     <= 1'b0;
    end else if (wr_en && (wb_i.adr == `CD_REG_CTRL)) begin
      cluster_id_o <= wb_i.dat[`CD_CID_W-1:0];
      alias_en_o   <= wb_i.dat[8];
      cnt_en_q     <= wb_i.dat[9];
    end
  end

  // Stall counters wrap, any write clears
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_sh_q <= '0;
      stall_l2_q <= '0;
    end else begin
      if (wr_en && (wb_i.adr == `CD_REG_STALL_SH)) begin
        stall_sh_q <= '0;
      end else if (cnt_en_q && stall_sh_i) begin
        stall_sh_q <= stall_sh_q + cnt_t'(1);
      end
      if (wr_en && (wb_i.adr == `CD_REG_STALL_L2)) begin
        stall_l2_q <= '0;
      end else if (cnt_en_q && stall_l2_i) begin
        stall_l2_q <= stall_l2_q + cnt_t'(1);
      end
    end
  end

  always_comb begin
    case (wb_i.adr)
      `CD_REG_CTRL:     rd_data = {22'b0, cnt_en_q, alias_en_o, 2'b0, cluster_id_o};
      `CD_REG_STALL_SH: rd_data = stall_sh_q;
      `CD_REG_STALL_L2: rd_data = stall_l2_q;
      default:          rd_data = '0;
    endcase
  end

  // Read data is valid together with ack
  always_ff @(posedge clk) begin
    if (access && !wb_i.we) begin
      wb_dat_o <= rd_data;
    end
  end

  // Ack never lasts two cycles
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

endmodule

//--- verilog/core_demux.sv
// ***************************************************************************
// Core data demux top level
// Router, PE transaction control, response mux and config registers
// ***************************************************************************

`timescale 1ns/100ps

module core_demux import core_demux_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,

  // Core side
  input  logic      core_req_valid_i,
  input  core_req_t core_req_i,
  output logic      core_gnt_o,
  output logic      core_rsp_valid_o,
  output core_rsp_t core_rsp_o,

  // Targets
  output core_req_t tgt_req_o,
  output logic      sh_req_o,
  input  logic      sh_gnt_i,
  input  logic      sh_rsp_valid_i,
  input  core_rsp_t sh_rsp_i,
  output logic      pe_req_o,
  input  logic      pe_gnt_i,
  input  logic      pe_rsp_valid_i,
  input  core_rsp_t pe_rsp_i,
  output logic      ext_req_o,
  input  logic      ext_gnt_i,
  input  logic      ext_rsp_valid_i,
  input  core_rsp_t ext_rsp_i,

  // Config port
  input  wb_req_t   wb_i,
  output data_t     wb_dat_o,
  output logic      wb_ack_o
);

  dest_e       dest;
  logic        pe_req;          // Core wants the PE side
  logic        pe_core_gnt;
  logic        pe_rsp_valid;    // After the response pipeline
  core_rsp_t   pe_rsp;
  logic        stall_sh;
  logic        stall_l2;
  cluster_id_t cluster_id;
  logic        alias_en;

  demux_req_router u_router (
    .core_req_valid_i ( core_req_valid_i ),
    .core_req_i       ( core_req_i       ),
    .cluster_id_i     ( cluster_id       ),
    .alias_en_i       ( alias_en         ),
    .sh_gnt_i         ( sh_gnt_i         ),
    .ext_gnt_i        ( ext_gnt_i        ),
    .pe_gnt_i         ( pe_core_gnt      ),
    .tgt_req_o        ( tgt_req_o        ),
    .sh_req_o         ( sh_req_o         ),
    .ext_req_o        ( ext_req_o        ),
    .pe_req_o         ( pe_req           ),
    .core_gnt_o       ( core_gnt_o       ),
    .stall_sh_o       ( stall_sh         ),
    .stall_l2_o       ( stall_l2         ),
    .dest_o           ( dest             )
  );

  periph_txn_ctrl u_pe_ctrl (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .pe_req_i       ( pe_req         ),
    .pe_gnt_i       ( pe_gnt_i       ),
    .pe_rsp_valid_i ( pe_rsp_valid_i ),
    .pe_rsp_i       ( pe_rsp_i       ),
    .pe_req_o       ( pe_req_o       ),
    .core_gnt_o     ( pe_core_gnt    ),
    .rsp_valid_o    ( pe_rsp_valid   ),
    .rsp_o          ( pe_rsp         )
  );

  demux_resp_mux u_resp_mux (
    .clk              ( clk              ),
    .rst_ni           ( rst_ni           ),
    .core_req_valid_i ( core_req_valid_i ),
    .dest_i           ( dest             ),
    .sh_rsp_valid_i   ( sh_rsp_valid_i   ),
    .sh_rsp_i         ( sh_rsp_i         ),
    .pe_rsp_valid_i   ( pe_rsp_valid     ),
    .pe_rsp_i         ( pe_rsp           ),
    .ext_rsp_valid_i  ( ext_rsp_valid_i  ),
    .ext_rsp_i        ( ext_rsp_i        ),
    .core_rsp_valid_o ( core_rsp_valid_o ),
    .core_rsp_o       ( core_rsp_o       )
  );

  demux_cfg_regs u_cfg_regs (
    .clk          ( clk        ),
    .rst_ni       ( rst_ni     ),
    .wb_i         ( wb_i       ),
    .stall_sh_i   ( stall_sh   ),
    .stall_l2_i   ( stall_l2   ),
    .wb_dat_o     ( wb_dat_o   ),
    .wb_ack_o     ( wb_ack_o   ),
    .cluster_id_o ( cluster_id ),
    .alias_en_o   ( alias_en   )
  );

endmodule

//--- dv/tb_core_demux.sv
// ***************************************************************************
// Testbench for the core data demux
// Clock and reset, SH/PE/EXT target models, stimulus table,
// Wishbone register tasks, PE timing and stall counter checks
// ***************************************************************************

`timescale 1ns/100ps
`include "core_demux_defines.svh"

module tb_core_demux import core_demux_pkg::*; ();

  typedef struct packed {
    addr_t      addr;
    logic       wen;
    data_t      wdata;
    dest_e      dest;
    logic [1:0] step;      // Config step that must be applied first
  } stim_t;

  localparam int unsigned TIMEOUT = 64;

  logic      clk;
  logic      rst_ni;
  logic      core_req_valid_i;
  core_req_t core_req_i;
  logic      core_gnt_o;
  logic      core_rsp_valid_o;
  core_rsp_t core_rsp_o;
  core_req_t tgt_req_o;
  logic      sh_req_o, pe_req_o, ext_req_o;
  logic      sh_gnt_i, pe_gnt_i, ext_gnt_i;
  logic      sh_rsp_valid_i, pe_rsp_valid_i, ext_rsp_valid_i;
  core_rsp_t sh_rsp_i, pe_rsp_i, ext_rsp_i;
  wb_req_t   wb_i;
  data_t     wb_dat_o;
  logic      wb_ack_o;

  logic [31:0] rng_state = 32'd1;
  stim_t       stim_q[$];
  logic        count_on = 1'b0;
  logic        cur_pe = 1'b0;     // Core transaction in flight goes to PE
  logic        prev_pe_rsp = 1'b0;
  logic        prev_pe_gnt = 1'b0;
  int unsigned sh_stalls = 0;
  int unsigned l2_stalls = 0;

  core_demux DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Target response rules
  function automatic core_rsp_t expected_rsp(addr_t addr, dest_e dest);
    core_rsp_t r;
    case (dest)
      DEST_SH:  r = '{rdata: addr ^ 32'hA5A5_A5A5, err: 1'b0};
      DEST_PE:  r = '{rdata: addr + 32'd1, err: addr[2]};
      default:  r = '{rdata: ~addr, err: addr[3]};
    endcase
    return r;
  endfunction

  task automatic stop_on_error(input string msg, input bit is_mismatch);
    $display("Test FAILED");
    if (is_mismatch) begin
      $display("mismatch at %0t ns: %s", $time, msg);
    end else begin
      $display("%s", msg);
    end
    $fatal(1);
  endtask

  task automatic add_stim(addr_t a, logic w, dest_e d, logic [1:0] s);
    stim_q.push_back('{addr: a, wen: w, wdata: ~a, dest: d, step: s});
  endtask

  // SH and EXT answer the cycle after their grant
  task automatic serve_fast(input dest_e d);
    addr_t       a;
    int unsigned wait_cyc;
    a = tgt_req_o.addr;
    wait_cyc = xorshift32() % 4;
    repeat (wait_cyc) @(posedge clk);
    @(posedge clk);
    #10;
    if (d == DEST_SH) begin
      sh_gnt_i = 1'b1;
    end else begin
      ext_gnt_i = 1'b1;
    end
    @(posedge clk);
    #10;
    if (d == DEST_SH) begin
      sh_gnt_i       = 1'b0;
      sh_rsp_valid_i = 1'b1;
      sh_rsp_i       = '{rdata: a ^ 32'hA5A5_A5A5, err: 1'b1};  // err must be masked
    end else begin
      ext_gnt_i       = 1'b0;
      ext_rsp_valid_i = 1'b1;
      ext_rsp_i       = '{rdata: ~a, err: a[3]};
    end
    @(posedge clk);
    #10;
    sh_rsp_valid_i  = 1'b0;
    ext_rsp_valid_i = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (sh_req_o) serve_fast(DEST_SH);
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (ext_req_o) serve_fast(DEST_EXT);
    end
  end

  // PE answers 1 to 3 cycles after its grant
  initial begin
    addr_t       a;
    int unsigned wait_cyc;
    int unsigned lat;
    forever begin
      @(negedge clk);
      if (pe_req_o) begin
        a = tgt_req_o.addr;
        wait_cyc = xorshift32() % 4;
        lat = 1 + xorshift32() % 3;
        repeat (wait_cyc) @(posedge clk);
        @(posedge clk);
        #10 pe_gnt_i = 1'b1;
        @(posedge clk);
        #10 pe_gnt_i = 1'b0;
        repeat (lat - 1) begin
          @(posedge clk);
          #10;
        end
        pe_rsp_valid_i = 1'b1;
        pe_rsp_i       = '{rdata: a + 32'd1, err: a[2]};
        @(posedge clk);
        #10 pe_rsp_valid_i = 1'b0;
      end
    end
  end

  // PE grant and response timing, stall cycle count
  always @(negedge clk) begin
    if (rst_ni) begin
      if (prev_pe_rsp) begin
        assert (core_gnt_o) else stop_on_error("no core grant after PE response", 1);
      end
      if (cur_pe && core_gnt_o) begin
        assert (prev_pe_rsp) else stop_on_error("PE core grant without PE response", 1);
      end
      if (prev_pe_gnt) begin
        assert (core_rsp_valid_o) else stop_on_error("no core response after PE grant", 1);
      end
      prev_pe_rsp = pe_rsp_valid_i;
      prev_pe_gnt = cur_pe && core_gnt_o;
      if (count_on) begin
        if (sh_req_o && !sh_gnt_i) sh_stalls++;
        if (core_req_valid_i && !sh_req_o && !core_gnt_o) l2_stalls++;
      end
    end
  end

  task automatic check_idle();
    assert (!sh_req_o && !pe_req_o && !ext_req_o && !core_gnt_o &&
            !core_rsp_valid_o && !wb_ack_o)
      else stop_on_error("output active while idle", 1);
  endtask

  task automatic wb_access(input wb_adr_t adr, input logic we, input data_t dat,
                           output data_t rdat);
    int unsigned n;
    @(posedge clk);
    #10 wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    n = 0;
    @(negedge clk);
    while (!wb_ack_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_on_error("Wishbone ack never arrived", 0);
    end
    assert (n == 1) else stop_on_error("Wishbone ack not in the cycle after strobe", 1);
    rdat = wb_dat_o;
    @(posedge clk);
    #10 wb_i = '0;
    @(negedge clk);
    assert (!wb_ack_o) else stop_on_error("Wishbone ack longer than one cycle", 1);
  endtask

  task automatic wb_check(input wb_adr_t adr, input data_t exp);
    data_t rd;
    wb_access(adr, 1'b0, '0, rd);
    assert (rd == exp)
      else stop_on_error($sformatf("reg 0x%0h read 0x%08h, expected 0x%08h", adr, rd, exp), 1);
  endtask

  task automatic apply_step(input logic [1:0] step);
    data_t rd;
    if (step == 2'd1) begin
      wb_access(`CD_REG_CTRL, 1'b1, 32'h0000_0103, rd);   // Cluster 3, alias on
      wb_check(`CD_REG_CTRL, 32'h0000_0103);
    end else begin
      wb_access(`CD_REG_CTRL, 1'b1, 32'h0000_0203, rd);   // Alias off, counting on
      wb_check(`CD_REG_CTRL, 32'h0000_0203);
      wb_access(`CD_REG_STALL_SH, 1'b1, '0, rd);
      wb_access(`CD_REG_STALL_L2, 1'b1, '0, rd);
      sh_stalls = 0;
      l2_stalls = 0;
      count_on  = 1'b1;
    end
  endtask

  task automatic do_access(input stim_t s);
    int unsigned n;
    core_req_t   req;
    core_rsp_t   exp;
    req = '{addr: s.addr, wen: s.wen, wdata: s.wdata, be: 4'hF};
    @(posedge clk);
    #10;
    core_req_valid_i = 1'b1;
    core_req_i = req;
    cur_pe = (s.dest == DEST_PE);
    @(negedge clk);
    assert (sh_req_o == (s.dest == DEST_SH) && ext_req_o == (s.dest == DEST_EXT) &&
            pe_req_o == (s.dest == DEST_PE))
      else stop_on_error($sformatf("addr 0x%08h went to the wrong target", s.addr), 1);
    assert (tgt_req_o == req)
      else stop_on_error($sformatf("target request 0x%0h, expected 0x%0h",
                                   tgt_req_o, req), 1);
    n = 0;
    while (!core_gnt_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_on_error("core grant never arrived", 0);
    end
    @(posedge clk);
    #10 core_req_valid_i = 1'b0;
    n = 0;
    @(negedge clk);
    while (!core_rsp_valid_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_on_error("core response never arrived", 0);
    end
    exp = expected_rsp(s.addr, s.dest);
    assert (core_rsp_o == exp)
      else stop_on_error($sformatf("addr 0x%08h rsp 0x%08h/%0b, expected 0x%08h/%0b",
                                   s.addr, core_rsp_o.rdata, core_rsp_o.err,
                                   exp.rdata, exp.err), 1);
    @(posedge clk);
    cur_pe = 1'b0;
  endtask

  initial begin
    logic [1:0] step;
    data_t      rd;
    rst_ni = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_i = '0;
    sh_gnt_i = 1'b0;
    pe_gnt_i = 1'b0;
    ext_gnt_i = 1'b0;
    sh_rsp_valid_i = 1'b0;
    pe_rsp_valid_i = 1'b0;
    ext_rsp_valid_i = 1'b0;
    sh_rsp_i = '0;
    pe_rsp_i = '0;
    ext_rsp_i = '0;
    wb_i = '0;

    // Reset configuration, cluster 0 with alias
    add_stim(32'h1000_0010, 1'b1, DEST_SH,  2'd0);
    add_stim(32'h1010_0004, 1'b0, DEST_SH,  2'd0);
    add_stim(32'h0000_0020, 1'b1, DEST_SH,  2'd0);
    add_stim(32'h0010_0008, 1'b1, DEST_SH,  2'd0);
    add_stim(32'h1020_4008, 1'b1, DEST_EXT, 2'd0);
    add_stim(32'h1020_0004, 1'b1, DEST_PE,  2'd0);
    add_stim(32'h0020_4000, 1'b0, DEST_EXT, 2'd0);
    add_stim(32'h0020_0000, 1'b1, DEST_PE,  2'd0);
    add_stim(32'h1030_0000, 1'b1, DEST_PE,  2'd0);
    add_stim(32'h2000_0004, 1'b1, DEST_PE,  2'd0);
    // Cluster 3, alias still on
    add_stim(32'h10C0_0000, 1'b1, DEST_SH,  2'd1);
    add_stim(32'h10D0_0010, 1'b1, DEST_SH,  2'd1);
    add_stim(32'h10E0_4008, 1'b1, DEST_EXT, 2'd1);
    add_stim(32'h10E0_0004, 1'b1, DEST_PE,  2'd1);
    add_stim(32'h1000_0000, 1'b1, DEST_PE,  2'd1);
    add_stim(32'h0000_0000, 1'b1, DEST_SH,  2'd1);
    // Alias off, stall counting on
    add_stim(32'h0000_0000, 1'b1, DEST_PE,  2'd2);
    add_stim(32'h0010_0004, 1'b0, DEST_PE,  2'd2);
    add_stim(32'h0020_4000, 1'b1, DEST_PE,  2'd2);
    add_stim(32'h10C0_0040, 1'b1, DEST_SH,  2'd2);
    add_stim(32'h10D0_0080, 1'b0, DEST_SH,  2'd2);
    add_stim(32'h10E0_4000, 1'b1, DEST_EXT, 2'd2);
    add_stim(32'h10E0_0000, 1'b1, DEST_PE,  2'd2);

    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    #10 rst_ni = 1'b1;
    @(negedge clk);
    check_idle();
    wb_check(`CD_REG_CTRL, 32'h0000_0100);

    step = 2'd0;
    foreach (stim_q[i]) begin
      if (stim_q[i].step != step) begin
        step = stim_q[i].step;
        apply_step(step);
      end
      do_access(stim_q[i]);
    end

    count_on = 1'b0;
    wb_check(`CD_REG_STALL_SH, data_t'(sh_stalls));
    wb_check(`CD_REG_STALL_L2, data_t'(l2_stalls));
    wb_access(`CD_REG_STALL_SH, 1'b1, '0, rd);
    wb_access(`CD_REG_STALL_L2, 1'b1, '0, rd);
    wb_check(`CD_REG_STALL_SH, '0);
    wb_check(`CD_REG_STALL_L2, '0);

    $display("Test OK");
    $finish;
  end

endmodule

//--- core_demux.f
+incdir+include
verilog/core_demux_pkg.sv
verilog/demux_req_router.sv
verilog/periph_txn_ctrl.sv
verilog/demux_resp_mux.sv
verilog/demux_cfg_regs.sv
verilog/core_demux.sv
dv/tb_core_demux.sv

//--- run_sim.sh
#!/bin/sh
# Build the core demux testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_core_demux \
  -f core_demux.f \
  -o Vtb_core_demux

# The run may stop with an error, the log decides
./obj_dir/Vtb_core_demux > sim.log 2>&1 || true
cat sim.log

if grep -q "Test OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
